/* hdl/afi_read_settings.svh */
/*
 * build-time sizes for the AFI read-return path, include this header in every
 * file that sizes a port, a type or a buffer from these values
 */

`ifndef AFI_READ_SETTINGS_SVH
`define AFI_READ_SETTINGS_SVH

// width of the calibrated read latency, the shifter has two to this power taps
`define MAX_LATENCY_COUNT_WIDTH 4

// width of one read word as it leaves the PHY towards the controller
`define AFI_DATA_WIDTH 32

// base-two log of the number of words the read data FIFO can hold
`define READ_FIFO_DEPTH_LOG2 3

`endif

/* hdl/afi_data_pkg.sv */
/*
 * data-side types of the read-return path, used by the read data FIFO and
 * by the top level wherever a read word or a FIFO pointer is carried
 */

`include "afi_read_settings.svh"

package afi_data_pkg;

	// one read word on the AFI side
	typedef logic [`AFI_DATA_WIDTH-1:0] afi_rdata_t;

	// number of entries in the read data FIFO
	localparam int READ_FIFO_DEPTH = 2 ** `READ_FIFO_DEPTH_LOG2;

	// FIFO pointer, the top bit is a wrap flag that tells full from empty
	// when the two pointers address the same entry
	typedef logic [`READ_FIFO_DEPTH_LOG2:0] fifo_ptr_t;

endpackage

/* hdl/read_latency_pkg.sv */
/*
 * latency-side types of the read-return path, shared by the shifter, the
 * valid selector, the calibrator and the top level
 */

`include "afi_read_settings.svh"

package read_latency_pkg;

	// number of taps in the latency shifter, one per possible latency value
	localparam int LATENCY_NUM = 2 ** `MAX_LATENCY_COUNT_WIDTH;

	// read latency in cycles as set by calibration
	typedef logic [`MAX_LATENCY_COUNT_WIDTH-1:0] latency_count_t;

	// shifter taps, bit k is tap k
	typedef logic [LATENCY_NUM-1:0] latency_vector_t;

endpackage

/* hdl/read_latency_shifter.sv */
/*
 * delays each controller read-enable pulse through a chain of taps, the
 * valid selector picks the tap that matches the calibrated latency
 */

`timescale 1ns/100ps

`include "afi_read_settings.svh"

module read_latency_shifter (
	input  logic                              pll_afi_clk,
	input  logic                              reset_n,
	input  logic                              rdata_en,
	output read_latency_pkg::latency_vector_t latency_shifter
);

	import read_latency_pkg::*;

	// every in-flight read is one set bit walking up the vector by one tap
	// per cycle, so several reads can share the chain without interfering
	// tap 0 goes high one cycle after the pulse, tap k after k+1 cycles
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// no reads are in flight after reset
			latency_shifter <= '0;
		end
		else
		begin
			// the oldest tap simply falls off the end of the chain
			latency_shifter <= {latency_shifter[LATENCY_NUM-2:0], rdata_en};
		end
	end

endmodule

/* hdl/read_valid_selector.sv */
/*
 * picks the shifter tap that matches the latency count and turns it into the
 * registered FIFO pop and the registered read valid strobe for the controller
 */

`timescale 1ns/100ps

`include "afi_read_settings.svh"

module read_valid_selector (
	input  logic                              reset_n,
	input  logic                              pll_afi_clk,
	input  read_latency_pkg::latency_vector_t latency_shifter,
	input  read_latency_pkg::latency_count_t  latency_counter,
	output logic                              read_enable,
	output logic                              read_valid
);

	import read_latency_pkg::*;

	// one-hot decode of the latency count, bit L set for latency L
	latency_vector_t selector;
	// registered decode, it follows a new count one cycle later
	latency_vector_t selector_reg;
	// shifter taps that survive the mask, at most one is expected to be set
	// for each read that reaches the chosen tap
	latency_vector_t valid_select;

	assign selector = latency_vector_t'(1) << latency_counter;

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			selector_reg <= '0;
		else
			selector_reg <= selector;
	end

	// a read arriving at tap L lines up with the registered decode here
	assign valid_select = selector_reg & latency_shifter;

	// both strobes come from the same masked taps, so the FIFO pop and the
	// valid seen by the controller always land in the same cycle
	// with a stable count L a pulse at t shows up here at t+2+L
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_enable <= 1'b0;
			read_valid <= 1'b0;
		end
		else
		begin
			read_enable <= |valid_select;
			read_valid <= |valid_select;
		end
	end

	// the FIFO pop and the controller valid must never drift apart
	a_enable_matches_valid : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		read_enable == read_valid
	);

endmodule

/* hdl/read_data_fifo.sv */
/*
 * show-ahead FIFO that holds captured read words until the delayed valid
 * strobe pops them, the head word is visible before the pop and flush
 * empties the buffer at the next edge
 */

`timescale 1ns/100ps

`include "afi_read_settings.svh"

module read_data_fifo (
	input  logic                    pll_afi_clk,
	input  logic                    reset_n,
	input  logic                    push,
	input  afi_data_pkg::afi_rdata_t push_data,
	input  logic                    pop,
	input  logic                    flush,
	output afi_data_pkg::afi_rdata_t head_data,
	output logic                    empty
);

	import afi_data_pkg::*;

	// storage for the captured words
	afi_rdata_t mem [READ_FIFO_DEPTH];

	// write and read pointers, each with a wrap bit on top
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;

	// set when every entry holds a word not yet popped
	logic full;

	// same entry and same wrap flag means nothing is stored
	assign empty = (wr_ptr == rd_ptr);

	// same entry but different wrap flag means the writer lapped the reader
	assign full = (wr_ptr[`READ_FIFO_DEPTH_LOG2] != rd_ptr[`READ_FIFO_DEPTH_LOG2]) &&
		(wr_ptr[`READ_FIFO_DEPTH_LOG2-1:0] == rd_ptr[`READ_FIFO_DEPTH_LOG2-1:0]);

	// the head is shown ahead of the pop, so data and valid line up
	assign head_data = mem[rd_ptr[`READ_FIFO_DEPTH_LOG2-1:0]];

	// data array, written on every push
	always_ff @(posedge pll_afi_clk)
	begin
		if (push)
			mem[wr_ptr[`READ_FIFO_DEPTH_LOG2-1:0]] <= push_data;
	end

	// pointer update, a flush wins over a push or a pop in the same cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (flush)
		begin
			// throws away whatever was stored, the calibration probe word
			// is the usual case
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// there is no back-pressure towards the memory, so a push into a full
	// buffer would lose a word
	a_no_push_when_full : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		(push && !flush) |-> !full
	);

	// a pop with nothing stored means the latency is set too short
	a_no_pop_when_empty : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		pop |-> !empty
	);

endmodule

/* hdl/read_latency_calibrator.sv */
/*
 * measures the read round trip with a single probe read and sets the read
 * latency from it, start with a cal_start pulse and wait for cal_done or
 * cal_fail, which stay high until the next start
 */

`timescale 1ns/100ps

`include "afi_read_settings.svh"

module read_latency_calibrator (
	input  logic                             pll_afi_clk,
	input  logic                             reset_n,
	input  logic                             cal_start,
	input  logic                             capture_valid,
	output logic                             probe_rdata_en,
	output read_latency_pkg::latency_count_t latency_count,
	output logic                             fifo_flush,
	output logic                             cal_done,
	output logic                             cal_fail
);

	import read_latency_pkg::*;

	// the probe must return within one shifter length or it cannot be used
	localparam int CAL_TIMEOUT = LATENCY_NUM;

	typedef enum logic [2:0] {
		CAL_IDLE,
		CAL_PROBE,
		CAL_MEASURE,
		CAL_FLUSH,
		CAL_DONE,
		CAL_FAIL
	} cal_state_t;

	cal_state_t state;

	// cycles since the probe pulse, wide enough to reach the timeout
	logic [`MAX_LATENCY_COUNT_WIDTH:0] cycle_count;

	// set when the probe came back but too early to give a usable latency
	logic probe_bad;

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= CAL_IDLE;
			cycle_count <= '0;
			probe_bad <= 1'b0;
			// the longest latency is the safe choice before calibration
			latency_count <= '1;
		end
		else
		begin
			case (state)
				CAL_IDLE, CAL_DONE, CAL_FAIL:
				begin
					// the result stays visible until a new start
					if (cal_start)
					begin
						state <= CAL_PROBE;
						probe_bad <= 1'b0;
					end
				end
				CAL_PROBE:
				begin
					// the probe goes out in this cycle, counting starts at one
					cycle_count <= 1;
					if (capture_valid)
					begin
						// a zero-cycle return cannot be real, flush and fail
						probe_bad <= 1'b1;
						state <= CAL_FLUSH;
					end
					else
						state <= CAL_MEASURE;
				end
				CAL_MEASURE:
				begin
					if (capture_valid)
					begin
						// a round trip of one cycle would need a negative latency
						if (cycle_count < 2)
							probe_bad <= 1'b1;
						else
							latency_count <= latency_count_t'(cycle_count - 1'b1);
						state <= CAL_FLUSH;
					end
					else if (cycle_count == CAL_TIMEOUT)
						state <= CAL_FAIL;
					else
						cycle_count <= cycle_count + 1'b1;
				end
				CAL_FLUSH:
				begin
					// the probe word is dropped from the FIFO in this cycle
					state <= probe_bad ? CAL_FAIL : CAL_DONE;
				end
				default:
					state <= CAL_IDLE;
			endcase
		end
	end

	// all outputs are plain decodes of the state
	assign probe_rdata_en = (state == CAL_PROBE);
	assign fifo_flush = (state == CAL_FLUSH);
	assign cal_done = (state == CAL_DONE);
	assign cal_fail = (state == CAL_FAIL);

	a_done_fail_exclusive : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		!(cal_done && cal_fail)
	);

endmodule

/* hdl/afi_read_path.sv */
/*
 * top level of the AFI read-return path, joins the latency shifter, the
 * valid selector, the read data FIFO and the latency calibrator
 */

`timescale 1ns/100ps

`include "afi_read_settings.svh"

module afi_read_path (
	input  logic                             pll_afi_clk,
	input  logic                             reset_n,
	input  logic                             afi_rdata_en,
	input  logic                             cal_start,
	input  logic                             capture_valid,
	input  afi_data_pkg::afi_rdata_t         capture_data,
	output logic                             phy_rdata_en,
	output afi_data_pkg::afi_rdata_t         afi_rdata,
	output logic                             afi_rdata_valid,
	output read_latency_pkg::latency_count_t afi_rlat,
	output logic                             cal_done,
	output logic                             cal_fail
);

	import afi_data_pkg::*;
	import read_latency_pkg::*;

	// taps of the shifter, one bit per read in flight
	latency_vector_t latency_shifter;
	// calibrated latency, shared by the selector and the status output
	latency_count_t latency_count;
	// FIFO pop, in step with afi_rdata_valid
	logic read_enable;
	logic probe_rdata_en;
	logic fifo_flush;
	logic fifo_empty;
	afi_rdata_t head_data;

	// the memory sees both controller reads and the calibration probe
	assign phy_rdata_en = afi_rdata_en | probe_rdata_en;

	// only controller reads enter the shifter, so the probe word is never
	// marked valid and is flushed instead
	read_latency_shifter i_shifter (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.rdata_en        (afi_rdata_en),
		.latency_shifter (latency_shifter)
	);

	read_valid_selector i_selector (
		.reset_n         (reset_n),
		.pll_afi_clk     (pll_afi_clk),
		.latency_shifter (latency_shifter),
		.latency_counter (latency_count),
		.read_enable     (read_enable),
		.read_valid      (afi_rdata_valid)
	);

	// every captured word is stored, the delayed strobe takes it out
	read_data_fifo i_fifo (
		.pll_afi_clk (pll_afi_clk),
		.reset_n     (reset_n),
		.push        (capture_valid),
		.push_data   (capture_data),
		.pop         (read_enable),
		.flush       (fifo_flush),
		.head_data   (head_data),
		.empty       (fifo_empty)
	);

	read_latency_calibrator i_calibrator (
		.pll_afi_clk    (pll_afi_clk),
		.reset_n        (reset_n),
		.cal_start      (cal_start),
		.capture_valid  (capture_valid),
		.probe_rdata_en (probe_rdata_en),
		.latency_count  (latency_count),
		.fifo_flush     (fifo_flush),
		.cal_done       (cal_done),
		.cal_fail       (cal_fail)
	);

	assign afi_rdata = head_data;
	assign afi_rlat = latency_count;

	// when calibration reports success the probe word must be gone, or the
	// first controller read would return it
	a_fifo_clean_after_cal : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		$rose(cal_done) |-> fifo_empty
	);

endmodule

/* dv/afi_read_path_tb.sv */
/*
 * self-checking testbench for the AFI read-return path, runs the tests listed
 * in dv/afi_read_stimulus.txt against a memory model with a fixed read delay
 */

`timescale 1ns/100ps

`include "afi_read_settings.svh"

module afi_read_path_tb;

	import afi_data_pkg::*;
	import read_latency_pkg::*;

	// wait limits in cycles, and the memory model pipe length
	localparam int WAIT_LIMIT = 64;
	localparam int PIPE_LEN = 32;

	logic pll_afi_clk;
	logic reset_n;
	logic afi_rdata_en;
	logic cal_start;
	logic capture_valid;
	afi_rdata_t capture_data;
	logic phy_rdata_en;
	afi_rdata_t afi_rdata;
	logic afi_rdata_valid;
	latency_count_t afi_rlat;
	logic cal_done;
	logic cal_fail;

	// memory model, entry i of the pipe is returned i+1 falling edges from now
	integer seed = 32'hdb76_200f;
	int mem_delay;
	logic mem_answers;
	logic pipe_valid [PIPE_LEN];
	afi_rdata_t pipe_data [PIPE_LEN];

	// expected reads in issue order, with the cycle each one is due
	int exp_due [$];
	afi_rdata_t exp_data [$];
	int cycle_num;
	int model_rlat;
	int valids_seen;

	string current_test;
	int test_errors;
	int tests_run;
	int tests_failed;
	logic timed_out;

	afi_read_path i_dut (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.afi_rdata_en    (afi_rdata_en),
		.cal_start       (cal_start),
		.capture_valid   (capture_valid),
		.capture_data    (capture_data),
		.phy_rdata_en    (phy_rdata_en),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid),
		.afi_rlat        (afi_rlat),
		.cal_done        (cal_done),
		.cal_fail        (cal_fail)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #50 pll_afi_clk = ~pll_afi_clk;
	end

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("error %0s: %0s expected %0h actual %0h", current_test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_condition(input logic cond, input string msg);
		assert (cond)
		else
		begin
			$display("in test %0s, %0s", current_test, msg);
			test_errors++;
		end
	endtask

	// the memory answers on the falling edge, like every other DUT input
	always @(negedge pll_afi_clk)
	begin
		capture_valid = pipe_valid[0];
		capture_data = pipe_data[0];
	end

	// memory model and scoreboard, sampled at the rising edge so that every
	// value seen is the one the DUT held through the cycle that just ended
	always @(posedge pll_afi_clk)
	begin
		int ended;
		logic missed;
		afi_rdata_t word;
		ended = cycle_num;
		cycle_num++;
		for (int i = 0; i < PIPE_LEN - 1; i++)
		begin
			pipe_valid[i] = pipe_valid[i + 1];
			pipe_data[i] = pipe_data[i + 1];
		end
		pipe_valid[PIPE_LEN - 1] = 1'b0;
		if (reset_n)
		begin
			// a read whose due cycle passed without a valid is dropped
			missed = (exp_due.size() != 0) && (exp_due[0] < ended);
			check_condition(!missed, "a read got no afi_rdata_valid in its due cycle");
			if (missed)
			begin
				void'(exp_due.pop_front());
				void'(exp_data.pop_front());
			end
			if (afi_rdata_valid)
			begin
				valids_seen++;
				check_condition(exp_due.size() != 0,
					"afi_rdata_valid was raised with no controller read outstanding");
				if (exp_due.size() != 0)
				begin
					check_value("afi_rdata_valid cycle", exp_due[0], ended);
					check_value("afi_rdata", exp_data[0], afi_rdata);
					void'(exp_due.pop_front());
					void'(exp_data.pop_front());
				end
			end
			// probe reads also get a word back, but only controller reads
			// are expected on afi_rdata_valid, 2+rlat cycles after issue
			if (phy_rdata_en && mem_answers)
			begin
				word = $random(seed);
				pipe_valid[mem_delay - 1] = 1'b1;
				pipe_data[mem_delay - 1] = word;
				if (afi_rdata_en)
				begin
					exp_due.push_back(ended + 2 + model_rlat);
					exp_data.push_back(word);
				end
			end
		end
	end

	task automatic report_test();
		tests_run++;
		if (test_errors == 0)
			$display("test %0s: pass", current_test);
		else
		begin
			tests_failed++;
			$display("test %0s: FAIL with %0d errors", current_test, test_errors);
		end
	endtask

	task automatic run_calibration();
		int waited;
		@(negedge pll_afi_clk);
		cal_start = 1'b1;
		@(negedge pll_afi_clk);
		cal_start = 1'b0;
		waited = 0;
		while (!cal_done && !cal_fail && waited < WAIT_LIMIT)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		if (!cal_done && !cal_fail)
		begin
			$display("timeout in test %0s, calibration ended neither done nor failed",
				current_test);
			test_errors++;
			timed_out = 1'b1;
		end
	endtask

	// back-to-back reads, one per cycle, then waits until all have returned
	task automatic run_reads(input int count);
		int waited;
		for (int i = 0; i < count; i++)
		begin
			@(negedge pll_afi_clk);
			afi_rdata_en = 1'b1;
		end
		@(negedge pll_afi_clk);
		afi_rdata_en = 1'b0;
		waited = 0;
		while (exp_due.size() != 0 && waited < WAIT_LIMIT)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		if (exp_due.size() != 0)
		begin
			$display("timeout in test %0s, reads never came back", current_test);
			test_errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input string name, input int delay, input int reads,
		input int answers, input int exp_rlat);
		logic expect_done;
		current_test = name;
		test_errors = 0;
		valids_seen = 0;
		mem_delay = delay;
		mem_answers = (answers != 0);
		// a silent memory or a round trip under two cycles keeps the old latency
		expect_done = (answers != 0) && (delay >= 2) && (delay <= LATENCY_NUM);
		check_value("stimulus file latency", expect_done ? delay - 1 : model_rlat, exp_rlat);
		run_calibration();
		if (!timed_out)
		begin
			check_value("cal_done", expect_done, cal_done);
			check_value("cal_fail", !expect_done, cal_fail);
			check_value("afi_rlat", exp_rlat, afi_rlat);
			model_rlat = exp_rlat;
			if (expect_done && reads > 0)
				run_reads(reads);
			check_value("afi_rdata_valid count", expect_done ? reads : 0, valids_seen);
		end
		report_test();
	endtask

	initial
	begin
		int fd;
		int fields;
		int delay;
		int reads;
		int answers;
		int exp_rlat;
		logic [8*128-1:0] line_buf;
		logic [8*32-1:0] name_buf;
		reset_n = 1'b0;
		afi_rdata_en = 1'b0;
		cal_start = 1'b0;
		capture_valid = 1'b0;
		capture_data = '0;
		for (int i = 0; i < PIPE_LEN; i++)
		begin
			pipe_valid[i] = 1'b0;
			pipe_data[i] = '0;
		end
		mem_delay = 1;
		mem_answers = 1'b0;
		cycle_num = 0;
		model_rlat = (1 << `MAX_LATENCY_COUNT_WIDTH) - 1;
		valids_seen = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		repeat (5) @(negedge pll_afi_clk);
		reset_n = 1'b1;

		// everything idle after reset, latency at its longest
		current_test = "reset";
		@(negedge pll_afi_clk);
		check_value("afi_rdata_valid", 0, afi_rdata_valid);
		check_value("phy_rdata_en", 0, phy_rdata_en);
		check_value("cal_done", 0, cal_done);
		check_value("cal_fail", 0, cal_fail);
		check_value("afi_rlat", model_rlat, afi_rlat);
		report_test();

		fd = $fopen("dv/afi_read_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file dv/afi_read_stimulus.txt");
			tests_failed++;
		end
		else
		begin
			// comment lines fail the scan after the first field and are skipped
			while (!$feof(fd) && !timed_out)
			begin
				line_buf = '0;
				name_buf = '0;
				if ($fgets(line_buf, fd) != 0)
				begin
					fields = $sscanf(line_buf, "%s %d %d %d %d", name_buf, delay, reads,
						answers, exp_rlat);
					if (fields == 5)
						run_test(string'(name_buf), delay, reads, answers, exp_rlat);
				end
			end
			$fclose(fd);
		end

		$display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
			tests_failed);
		if (tests_failed == 0 && !timed_out && tests_run > 1)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+hdl
hdl/afi_data_pkg.sv
hdl/read_latency_pkg.sv
hdl/read_latency_shifter.sv
hdl/read_valid_selector.sv
hdl/read_data_fifo.sv
hdl/read_latency_calibrator.sv
hdl/afi_read_path.sv
dv/afi_read_path_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the AFI read path testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module afi_read_path_tb -o afi_read_path_tb > build.log 2>&1 \
	|| { cat build.log; echo "build failed, see build.log"; exit 1; }

./obj_dir/afi_read_path_tb > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log \
	|| { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation PASSED"

/* dv/afi_read_stimulus.txt */
# columns: test name, memory delay in cycles, back-to-back reads, memory answers (1 or 0),
# expected afi_rlat after calibration, delay minus one or the old value when calibration fails
single_read 5 1 1 4
burst_read 5 8 1 4
recal_short 2 6 1 1
recal_long 12 10 1 11
no_answer 7 0 0 11
too_fast 1 0 1 11
after_fail 9 4 1 8
